// File: common/rv_ex_pkg.sv
package rv_ex_pkg;

    // Widths
    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int rob_idx_w = 4;
    localparam int exc_w     = 3;
    localparam int shamt_w   = 5;

    // Sequential PC step, used for link addresses
    localparam logic [xlen-1:0] pc_step = 32'd4;

    // funct3 codes for OP and OP-IMM
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    // funct3 codes for conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // RV32I major opcodes handled by execute
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011,
        load   = 7'b0000011,
        store  = 7'b0100011
    } opcode_e;

    // Unit that completes the instruction in the ROB
    typedef enum logic [2:0] {
        instr_alu    = 3'd0,
        instr_load   = 3'd1,
        instr_store  = 3'd2,
        instr_branch = 3'd3,
        instr_jump   = 3'd4
    } instr_type_e;

    // Operand source select
    typedef enum logic [1:0] {
        fwd_none  = 2'b00,
        fwd_memwb = 2'b01,
        fwd_exmem = 2'b10
    } fwd_sel_e;

    // Decoded instruction entering execute
    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      pc;
        opcode_e              opcode;
        logic [2:0]           funct3;
        logic [6:0]           funct7;
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      data_rs1;
        logic [xlen-1:0]      data_rs2;
        logic [xlen-1:0]      immediate;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_to_reg;
        logic                 write_enable;
        logic                 branch_inst;
        instr_type_e          instr_type;
        logic [rob_idx_w-1:0] rob_idx;
        logic [exc_w-1:0]     exception_vector;
    } idex_t;

    // EX/MEM register contents
    typedef struct packed {
        logic                 valid;
        logic [xlen-1:0]      alu_out;
        logic [xlen-1:0]      target_pc;
        logic [xlen-1:0]      store_data;
        logic [reg_idx_w-1:0] rd;
        logic [2:0]           funct3;
        instr_type_e          instr_type;
        logic                 mem_read;
        logic                 mem_write;
        logic                 mem_to_reg;
        logic                 write_enable;
        logic                 branch_inst;
        logic                 branch_taken;
        logic                 complete;
        logic [rob_idx_w-1:0] rob_idx;
        logic [exc_w-1:0]     exception_vector;
    } exmem_t;

    // Write-back value offered for forwarding
    typedef struct packed {
        logic                 write_enable;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      data;
    } wb_fwd_t;

endpackage

// File: execute/alu.sv
`timescale 1ns/1ns

module alu (
    input  rv_ex_pkg::opcode_e          opcode,
    input  logic [2:0]                  funct3,
    input  logic [6:0]                  funct7,
    input  logic [rv_ex_pkg::xlen-1:0]  operand1,
    input  logic [rv_ex_pkg::xlen-1:0]  operand2,
    input  logic [rv_ex_pkg::xlen-1:0]  immediate,
    input  logic [rv_ex_pkg::xlen-1:0]  pc,
    output logic [rv_ex_pkg::xlen-1:0]  alu_out,
    output logic [rv_ex_pkg::xlen-1:0]  target_pc,
    output logic                        branch_taken
);
    import rv_ex_pkg::*;

    logic [xlen-1:0]    operand_b;
    logic [shamt_w-1:0] shamt;
    logic               use_sub;
    logic [xlen-1:0]    add_sub;
    logic               lt_signed;
    logic               lt_unsigned;
    logic               equal;
    logic [xlen-1:0]    arith_out;
    logic [xlen-1:0]    addr_sum;
    logic [xlen-1:0]    pc_imm;
    logic [xlen-1:0]    pc_link;
    logic               cond_met;

    // Immediate replaces rs2 only for OP-IMM; branches compare rs1 with rs2
    assign operand_b = (opcode == op_imm) ? immediate : operand2;
    assign shamt     = operand_b[shamt_w-1:0];

    // SUB exists only in register form, addi with a negative imm must not subtract
    assign use_sub = (opcode == op) && funct7[5];
    assign add_sub = use_sub ? (operand1 - operand_b) : (operand1 + operand_b);

    // Shared comparator for slt/sltu and branches
    assign lt_signed   = $signed(operand1) < $signed(operand_b);
    assign lt_unsigned = operand1 < operand_b;
    assign equal       = operand1 == operand_b;

    assign addr_sum = operand1 + immediate;
    assign pc_imm   = pc + immediate;
    assign pc_link  = pc + pc_step;

    always_comb begin
        case (funct3)
            f3_add_sub: arith_out = add_sub;
            f3_sll:     arith_out = operand1 << shamt;
            f3_slt:     arith_out = {{(xlen-1){1'b0}}, lt_signed};
            f3_sltu:    arith_out = {{(xlen-1){1'b0}}, lt_unsigned};
            f3_xor:     arith_out = operand1 ^ operand_b;
            f3_srl_sra: begin
                if (funct7[5]) begin
                    arith_out = $unsigned($signed(operand1) >>> shamt);
                end else begin
                    arith_out = operand1 >> shamt;
                end
            end
            f3_or:      arith_out = operand1 | operand_b;
            f3_and:     arith_out = operand1 & operand_b;
            default:    arith_out = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            op, op_imm:  alu_out = arith_out;
            lui:         alu_out = immediate;
            auipc:       alu_out = pc_imm;
            jal, jalr:   alu_out = pc_link;
            load, store: alu_out = addr_sum;
            default:     alu_out = '0;
        endcase
    end

    // jalr target comes from rs1 with the low bit dropped
    always_comb begin
        if (opcode == jalr) begin
            target_pc = {addr_sum[xlen-1:1], 1'b0};
        end else begin
            target_pc = pc_imm;
        end
    end

    always_comb begin
        case (funct3)
            f3_beq:  cond_met = equal;
            f3_bne:  cond_met = !equal;
            f3_blt:  cond_met = lt_signed;
            f3_bge:  cond_met = !lt_signed;
            f3_bltu: cond_met = lt_unsigned;
            f3_bgeu: cond_met = !lt_unsigned;
            default: cond_met = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            branch:    branch_taken = cond_met;
            jal, jalr: branch_taken = 1'b1;
            default:   branch_taken = 1'b0;
        endcase
    end

endmodule

// File: execute/forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit (
    input  logic [rv_ex_pkg::reg_idx_w-1:0] rs1,
    input  logic [rv_ex_pkg::reg_idx_w-1:0] rs2,
    input  logic [rv_ex_pkg::reg_idx_w-1:0] exmem_rd,
    input  logic                            exmem_write_enable,
    input  logic [rv_ex_pkg::reg_idx_w-1:0] wb_rd,
    input  logic                            wb_write_enable,
    output rv_ex_pkg::fwd_sel_e             fwd_a,
    output rv_ex_pkg::fwd_sel_e             fwd_b
);
    import rv_ex_pkg::*;

    // Youngest producer wins, x0 is never forwarded
    function automatic fwd_sel_e pick_source(
        input logic [reg_idx_w-1:0] src,
        input logic [reg_idx_w-1:0] ex_rd,
        input logic                 ex_we,
        input logic [reg_idx_w-1:0] mw_rd,
        input logic                 mw_we
    );
        fwd_sel_e sel;
        if (ex_we && (ex_rd != '0) && (ex_rd == src)) begin
            sel = fwd_exmem;
        end else if (mw_we && (mw_rd != '0) && (mw_rd == src)) begin
            sel = fwd_memwb;
        end else begin
            sel = fwd_none;
        end
        return sel;
    endfunction

    assign fwd_a = pick_source(rs1, exmem_rd, exmem_write_enable, wb_rd, wb_write_enable);
    assign fwd_b = pick_source(rs2, exmem_rd, exmem_write_enable, wb_rd, wb_write_enable);

endmodule

// File: execute/stage_execute.sv
`timescale 1ns/1ns

module stage_execute (
    input  rv_ex_pkg::idex_t   idex,
    input  rv_ex_pkg::exmem_t  exmem,
    input  rv_ex_pkg::wb_fwd_t wb,
    output rv_ex_pkg::exmem_t  ex_result,
    output logic               flush
);
    import rv_ex_pkg::*;

    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;
    logic            exmem_writes;
    logic [xlen-1:0] operand1;
    logic [xlen-1:0] operand2;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] target_pc;
    logic            branch_taken;

    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [xlen-1:0] rf_value,
        input logic [xlen-1:0] exmem_value,
        input logic [xlen-1:0] wb_value
    );
        logic [xlen-1:0] value;
        case (sel)
            fwd_exmem: value = exmem_value;
            fwd_memwb: value = wb_value;
            default:   value = rf_value;
        endcase
        return value;
    endfunction

    // A bubble sitting in EX/MEM must not forward
    assign exmem_writes = exmem.valid & exmem.write_enable;

    forwarding_unit u_forwarding (
        .rs1                (idex.rs1),
        .rs2                (idex.rs2),
        .exmem_rd           (exmem.rd),
        .exmem_write_enable (exmem_writes),
        .wb_rd              (wb.rd),
        .wb_write_enable    (wb.write_enable),
        .fwd_a              (fwd_a),
        .fwd_b              (fwd_b)
    );

    // Load-use hazards are resolved upstream, so alu_out is safe to forward here
    assign operand1 = fwd_mux(fwd_a, idex.data_rs1, exmem.alu_out, wb.data);
    assign operand2 = fwd_mux(fwd_b, idex.data_rs2, exmem.alu_out, wb.data);

    alu u_alu (
        .opcode       (idex.opcode),
        .funct3       (idex.funct3),
        .funct7       (idex.funct7),
        .operand1     (operand1),
        .operand2     (operand2),
        .immediate    (idex.immediate),
        .pc           (idex.pc),
        .alu_out      (alu_out),
        .target_pc    (target_pc),
        .branch_taken (branch_taken)
    );

    always_comb begin
        ex_result.valid            = idex.valid;
        ex_result.alu_out          = alu_out;
        ex_result.target_pc        = target_pc;
        // Store data taken after forwarding
        ex_result.store_data       = operand2;
        ex_result.rd               = idex.rd;
        ex_result.funct3           = idex.funct3;
        ex_result.instr_type       = idex.instr_type;
        // Side effects of a bubble are suppressed here
        ex_result.mem_read         = idex.mem_read & idex.valid;
        ex_result.mem_write        = idex.mem_write & idex.valid;
        ex_result.mem_to_reg       = idex.mem_to_reg;
        ex_result.write_enable     = idex.write_enable & idex.valid;
        ex_result.branch_inst      = idex.branch_inst;
        ex_result.branch_taken     = branch_taken & idex.valid;
        ex_result.complete         = idex.valid &&
                                     (idex.instr_type inside {instr_alu, instr_jump});
        ex_result.rob_idx          = idex.rob_idx;
        ex_result.exception_vector = idex.exception_vector;
    end

    assign flush = branch_taken & idex.valid;

endmodule

// File: design/ex_mem_register.sv
`timescale 1ns/1ns

module ex_mem_register (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              stall,
    input  rv_ex_pkg::exmem_t d,
    output rv_ex_pkg::exmem_t q
);

    // All-zero contents leave valid, enables and complete inactive
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// File: design/execute_top.sv
`timescale 1ns/1ns

module execute_top (
    input  logic               clk,
    input  logic               arst_n,
    input  rv_ex_pkg::idex_t   idex,
    input  rv_ex_pkg::wb_fwd_t wb,
    input  logic               stall,
    output rv_ex_pkg::exmem_t  exmem,
    output logic               flush
);
    import rv_ex_pkg::*;

    exmem_t ex_result;

    // Registered exmem also feeds back as the EX/MEM forwarding source
    stage_execute u_stage_execute (
        .idex      (idex),
        .exmem     (exmem),
        .wb        (wb),
        .ex_result (ex_result),
        .flush     (flush)
    );

    // Upstream holds idex while stall is high
    ex_mem_register u_ex_mem_register (
        .clk    (clk),
        .arst_n (arst_n),
        .stall  (stall),
        .d      (ex_result),
        .q      (exmem)
    );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic arst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held for 16 cycles
    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// File: bench/tb_execute_top.sv
`timescale 1ns/1ns

module tb_execute_top;
    import rv_ex_pkg::*;

    logic    clk;
    logic    arst_n;
    idex_t   idex;
    wb_fwd_t wb;
    logic    stall;
    exmem_t  exmem;
    logic    flush;

    idex_t   stim_idex[$];
    wb_fwd_t stim_wb[$];
    logic    stim_stall[$];
    exmem_t  exp_exmem[$];
    logic    exp_flush[$];
    string   names[$];
    int      case_bad[$];

    integer seed        = 32'hb506;
    int     cycles      = 0;
    int     cycle_limit = 100000;
    int     passed      = 0;
    int     failed      = 0;

    tb_clock u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    execute_top DUT (
        .clk    (clk),
        .arst_n (arst_n),
        .idex   (idex),
        .wb     (wb),
        .stall  (stall),
        .exmem  (exmem),
        .flush  (flush)
    );

    // Name of the next record, comment lines skipped
    task automatic next_record_name(input int fd, output string name, output bit ok);
        string rest;
        int    code;
        ok = 0;
        code = $fscanf(fd, "%s", name);
        while (code == 1 && !ok) begin
            if (name[0] == "#") begin
                void'($fgets(rest, fd));
                code = $fscanf(fd, "%s", name);
            end else begin
                ok = 1;
            end
        end
    endtask

    task automatic load_cases();
        int            fd;
        string         name;
        bit            ok;
        logic [31:0]   f[0:22];
        logic [31:0]   e[0:7];
        idex_t         s;
        wb_fwd_t       w;
        exmem_t        x;
        logic [exc_w-1:0] held_exc;
        held_exc = '0;
        fd = $fopen("bench/execute_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file bench/execute_cases.txt");
            $display("Some tests failed");
            $finish;
        end else begin
            next_record_name(fd, name, ok);
            while (ok) begin
                // Stimulus fields, stall last
                for (int k = 0; k < 23; k++) begin
                    void'($fscanf(fd, "%h", f[k]));
                end
                // Expected fields on the following line
                for (int k = 0; k < 8; k++) begin
                    void'($fscanf(fd, "%h", e[k]));
                end
                s = '0;
                s.valid = f[0][0];
                s.pc = f[1];
                s.opcode = opcode_e'(f[2][6:0]);
                s.funct3 = f[3][2:0];
                s.funct7 = f[4][6:0];
                s.rs1 = f[5][4:0];
                s.rs2 = f[6][4:0];
                s.rd = f[7][4:0];
                s.data_rs1 = f[8];
                s.data_rs2 = f[9];
                s.immediate = f[10];
                s.mem_read = f[11][0];
                s.mem_write = f[12][0];
                s.mem_to_reg = f[13][0];
                s.write_enable = f[14][0];
                s.branch_inst = f[15][0];
                s.instr_type = instr_type_e'(f[16][2:0]);
                s.rob_idx = f[17][3:0];
                s.exception_vector = f[18][2:0];
                w.write_enable = f[19][0];
                w.rd = f[20][4:0];
                w.data = f[21];
                // A stalled record expects the held contents
                if (!f[22][0]) begin
                    held_exc = s.exception_vector;
                end
                x = '0;
                x.valid = e[0][0];
                x.alu_out = e[1];
                x.target_pc = e[2];
                x.store_data = e[3];
                x.branch_taken = e[4][0];
                x.complete = e[5][0];
                x.rob_idx = e[6][3:0];
                x.exception_vector = held_exc;
                stim_idex.push_back(s);
                stim_wb.push_back(w);
                stim_stall.push_back(f[22][0]);
                exp_exmem.push_back(x);
                exp_flush.push_back(e[7][0]);
                names.push_back(name);
                case_bad.push_back(0);
                next_record_name(fd, name, ok);
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_field(input string what, input int idx, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("Mismatch at %0t: case %s %s got %h expected %h",
                     $time, names[idx], what, got, want);
            case_bad[idx]++;
        end
    endtask

    task automatic check_exmem(input int idx);
        exmem_t x;
        x = exp_exmem[idx];
        compare_field("valid", idx, exmem.valid, x.valid);
        compare_field("alu_out", idx, exmem.alu_out, x.alu_out);
        compare_field("target_pc", idx, exmem.target_pc, x.target_pc);
        compare_field("store_data", idx, exmem.store_data, x.store_data);
        compare_field("branch_taken", idx, exmem.branch_taken, x.branch_taken);
        compare_field("complete", idx, exmem.complete, x.complete);
        compare_field("rob_idx", idx, exmem.rob_idx, x.rob_idx);
        compare_field("exception_vector", idx, exmem.exception_vector, x.exception_vector);
        if (case_bad[idx] == 0) begin
            passed++;
            $display("Case %0d %s: ok", idx, names[idx]);
        end else begin
            failed++;
            $display("Case %0d %s: FAIL", idx, names[idx]);
        end
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        wb_fwd_t w;
        idex  = '0;
        wb    = '0;
        stall = 1'b0;
        load_cases();
        cycle_limit = 4 * names.size() + 100;
        // Live instruction on idex while reset is asserted
        if (names.size() > 0) begin
            idex = stim_idex[0];
        end
        wait (arst_n === 1'b1);
        @(negedge clk);
        if (exmem !== '0) begin
            $display("Mismatch at %0t: reset left exmem at %h", $time, exmem);
            failed++;
            $display("Reset check: FAIL");
        end else begin
            passed++;
            $display("Reset check: ok");
        end
        for (int i = 0; i <= names.size(); i++) begin
            @(posedge clk);
            if (i < names.size()) begin
                w = stim_wb[i];
                // Unused write-back data is scrambled
                if (!w.write_enable) begin
                    w.data = $random(seed);
                end
                idex  <= stim_idex[i];
                wb    <= w;
                stall <= stim_stall[i];
            end
            @(negedge clk);
            if (i > 0) begin
                check_exmem(i - 1);
            end
            if (i < names.size()) begin
                if (flush !== exp_flush[i]) begin
                    $display("Mismatch at %0t: case %s flush got %b expected %b",
                             $time, names[i], flush, exp_flush[i]);
                    case_bad[i]++;
                end
            end
        end
        $display("Done: %0d passed, %0d failed", passed, failed);
        if (failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: bench/execute_cases.txt
# stim: name v pc opc f3 f7 rs1 rs2 rd d1 d2 imm mr mw m2r we bi type rob exc wb_we wb_rd wb_data stall
# expect (next line, exmem after the edge): v alu_out target_pc store_data br_taken complete rob flush
add 1 00000100 33 0 00 01 02 03 00000005 00000007 00000000 0 0 0 1 0 0 1 0 0 00 00000000 0
1 0000000c 00000100 00000007 0 1 1 0
sub 1 00000104 33 0 20 04 05 06 00000003 00000005 00000000 0 0 0 1 0 0 2 0 0 00 00000000 0
1 fffffffe 00000104 00000005 0 1 2 0
srai 1 00000108 13 5 20 07 04 08 80000000 00000000 00000404 0 0 0 1 0 0 3 0 0 00 00000000 0
1 f8000000 0000050c 00000000 0 1 3 0
sltu 1 0000010c 33 3 00 09 0a 0b 00000001 ffffffff 00000000 0 0 0 1 0 0 4 0 0 00 00000000 0
1 00000001 0000010c ffffffff 0 1 4 0
slt 1 00000110 33 2 00 0c 0d 0e ffffffff 00000001 00000000 0 0 0 1 0 0 5 0 0 00 00000000 0
1 00000001 00000110 00000001 0 1 5 0
xori 1 00000114 13 4 00 0f 00 10 0000ff00 00000000 ffffffff 0 0 0 1 0 0 6 0 0 00 00000000 0
1 ffff00ff 00000113 00000000 0 1 6 0
sll 1 00000118 33 1 00 11 12 13 00000003 00000024 00000000 0 0 0 1 0 0 7 0 0 00 00000000 0
1 00000030 00000118 00000024 0 1 7 0
lui 1 0000011c 37 0 00 00 00 14 00000000 00000000 12345000 0 0 0 1 0 0 8 3 0 00 00000000 0
1 12345000 1234511c 00000000 0 1 8 0
auipc 1 00000120 17 0 00 00 00 15 00000000 00000000 00001000 0 0 0 1 0 0 9 0 0 00 00000000 0
1 00001120 00001120 00000000 0 1 9 0
addi 1 00000124 13 0 00 00 00 16 00000000 00000000 00000abc 0 0 0 1 0 0 a 0 0 00 00000000 0
1 00000abc 00000be0 00000000 0 1 a 0
fwd_exmem 1 00000128 33 0 00 16 00 17 11111111 00000001 00000000 0 0 0 1 0 0 b 0 1 16 22222222 0
1 00000abd 00000128 00000001 0 1 b 0
addi_x0 1 0000012c 13 0 00 00 00 00 00000000 00000000 00000055 0 0 0 1 0 0 c 0 0 00 00000000 0
1 00000055 00000181 00000000 0 1 c 0
no_fwd_x0 1 00000130 33 0 00 00 00 18 00000000 00000000 00000000 0 0 0 1 0 0 d 0 1 00 33333333 0
1 00000000 00000130 00000000 0 1 d 0
fwd_wb 1 00000134 33 0 00 19 00 1a 00000000 00000002 00000000 0 0 0 1 0 0 e 0 1 19 00000100 0
1 00000102 00000134 00000002 0 1 e 0
store 1 00000138 23 2 00 01 1a 00 00002000 deadbeef 00000010 0 1 0 0 0 2 f 0 0 00 00000000 0
1 00002010 00000148 00000102 0 0 f 0
beq 1 00000200 63 0 00 01 02 00 00000005 00000005 00000020 0 0 0 0 1 3 0 0 0 00 00000000 0
1 00000000 00000220 00000005 1 0 0 1
bne 1 00000204 63 1 00 01 02 00 00000005 00000005 00000020 0 0 0 0 1 3 1 0 0 00 00000000 0
1 00000000 00000224 00000005 0 0 1 0
blt 1 00000208 63 4 00 01 02 00 ffffffff 00000001 00000020 0 0 0 0 1 3 2 0 0 00 00000000 0
1 00000000 00000228 00000001 1 0 2 1
bge 1 0000020c 63 5 00 01 02 00 ffffffff 00000001 00000020 0 0 0 0 1 3 3 0 0 00 00000000 0
1 00000000 0000022c 00000001 0 0 3 0
bltu 1 00000210 63 6 00 01 02 00 ffffffff 00000001 00000020 0 0 0 0 1 3 4 0 0 00 00000000 0
1 00000000 00000230 00000001 0 0 4 0
bgeu 1 00000214 63 7 00 01 02 00 ffffffff 00000001 00000020 0 0 0 0 1 3 5 0 0 00 00000000 0
1 00000000 00000234 00000001 1 0 5 1
jal 1 00000300 6f 0 00 00 00 01 00000000 00000000 00000100 0 0 0 1 0 4 1 5 0 00 00000000 0
1 00000304 00000400 00000000 1 1 1 1
jalr 1 00000308 67 0 00 02 00 03 00001003 00000000 00000004 0 0 0 1 0 4 2 0 0 00 00000000 0
1 0000030c 00001006 00000000 1 1 2 1
load 1 00000310 03 2 00 04 00 05 00003000 00000000 fffffffc 1 0 1 1 0 1 3 0 0 00 00000000 0
1 00002ffc 0000030c 00000000 0 0 3 0
bubble 0 00000314 33 0 00 06 07 08 00000001 00000002 00000000 0 0 0 1 0 0 4 0 0 00 00000000 0
0 00000003 00000314 00000002 0 0 4 0
add_pre 1 00000318 33 0 00 01 02 09 00000010 00000020 00000000 0 0 0 1 0 0 4 0 0 00 00000000 0
1 00000030 00000318 00000020 0 1 4 0
add_stall 1 0000031c 33 0 00 0a 0b 0c 00000001 00000001 00000000 0 0 0 1 0 0 5 7 0 00 00000000 1
1 00000030 00000318 00000020 0 1 4 0
add_go 1 0000031c 33 0 00 0a 0b 0c 00000001 00000001 00000000 0 0 0 1 0 0 5 7 0 00 00000000 0
1 00000002 0000031c 00000001 0 1 5 0

// File: build.f
common/rv_ex_pkg.sv
execute/alu.sv
execute/forwarding_unit.sv
execute/stage_execute.sv
design/ex_mem_register.sv
design/execute_top.sv
bench/tb_clock.sv
bench/tb_execute_top.sv
